// ==== hw/rtc_pkg.sv ====
//////////////////////////////
// RTC shared definitions
// Register map, sequencer states, prescaler constants and the
// BCD or binary field increment used by the time counter.
//////////////////////////////

`default_nettype none

package rtc_pkg;

    typedef logic [7:0] time_byte_t;

    localparam int INDEX_W = 7;

    typedef enum logic [INDEX_W-1:0] {
        REG_SECONDS       = 7'h00,
        REG_ALARM_SECONDS = 7'h01,
        REG_MINUTES       = 7'h02,
        REG_ALARM_MINUTES = 7'h03,
        REG_HOURS         = 7'h04,
        REG_ALARM_HOURS   = 7'h05,
        REG_STATUS_A      = 7'h0A,
        REG_STATUS_B      = 7'h0B,
        REG_STATUS_C      = 7'h0C,
        REG_STATUS_D      = 7'h0D
    } reg_index_t;

    typedef enum logic [2:0] {
        SEC_UPDATE_START       = 3'd0,
        SEC_UPDATE_IN_PROGRESS = 3'd1,
        SEC_SECOND_START       = 3'd2,
        SEC_SECOND_IN_PROGRESS = 3'd3,
        SEC_STOPPED            = 3'd4
    } sec_state_t;

    // Prescaler and once-per-second pacing.
    localparam int                RATE_W             = 28;
    localparam logic [RATE_W-1:0] TICK_HZ            = 800;
    localparam int                TICKS_PER_SECOND   = 800;
    localparam int                FIRST_SECOND_TICKS = 4;
    localparam int                COUNT_W            = 11;

    localparam logic [1:0] ALARM_ANY = 2'b11;

    // Minutes wrap at the same limit as seconds.
    localparam time_byte_t SEC_LIMIT_BIN  = 8'd59;
    localparam time_byte_t SEC_LIMIT_BCD  = 8'h59;
    localparam time_byte_t HOUR_LIMIT_BIN = 8'd23;
    localparam time_byte_t HOUR_LIMIT_BCD = 8'h23;

    // Returns the field plus one, or zero once the limit is reached.
    function automatic time_byte_t next_field(
        input time_byte_t value,
        input time_byte_t limit,
        input logic       binary_mode
    );
        time_byte_t result;
        if (value >= limit) begin
            result = '0;
        end else if (!binary_mode && value[3:0] >= 4'd9) begin
            result = {value[7:4] + 4'd1, 4'h0};
        end else begin
            result = value + 8'd1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== hw/rtc_time_if.sv ====
//////////////////////////////
// RTC time bus
// Register writes and mode go to the time counter, and the clock
// fields and alarm match come back to the register block.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface rtc_time_if;
    import rtc_pkg::*;

    logic       wr_en;
    reg_index_t wr_index;
    time_byte_t wr_data;
    logic       binary_mode;

    time_byte_t second;
    time_byte_t minute;
    time_byte_t hour;
    time_byte_t alarm_second;
    time_byte_t alarm_minute;
    time_byte_t alarm_hour;
    logic       alarm_hit;

    modport regs (
        output wr_en, wr_index, wr_data, binary_mode,
        input  second, minute, hour, alarm_second, alarm_minute, alarm_hour, alarm_hit
    );

    modport counter (
        input  wr_en, wr_index, wr_data, binary_mode,
        output second, minute, hour, alarm_second, alarm_minute, alarm_hour, alarm_hit
    );

endinterface

`default_nettype wire

// ==== hw/rtc_tick_gen.sv ====
//////////////////////////////
// RTC tick generator
// Fractional accumulator giving an average 800 Hz tick.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_tick_gen (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [rtc_pkg::RATE_W-1:0] clock_rate,
    output logic                     tick
);
    import rtc_pkg::*;

    logic [RATE_W-1:0] acc;
    logic [RATE_W:0]   acc_sum;

    // One extra bit so the sum cannot wrap for rates near the top of the range.
    assign acc_sum = {1'b0, acc} + {1'b0, TICK_HZ};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (acc_sum >= {1'b0, clock_rate}) begin
            acc  <= RATE_W'(acc_sum - {1'b0, clock_rate});
            tick <= 1'b1;
        end else begin
            acc  <= acc_sum[RATE_W-1:0];
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rtc_seq_ctrl.sv ====
//////////////////////////////
// RTC update sequencer
// Counts 800 Hz ticks and issues the once-per-second step,
// and reports the update-in-progress window.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_seq_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  tick,
    input  wire  freeze,
    output logic step,
    output logic update_in_progress
);
    import rtc_pkg::*;

    sec_state_t         state;
    logic [COUNT_W-1:0] countdown;
    logic               count_zero;

    assign count_zero         = (countdown == '0);
    assign step               = (state == SEC_SECOND_START);
    assign update_in_progress = (state == SEC_UPDATE_IN_PROGRESS) ||
                                (state == SEC_SECOND_START);

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SEC_UPDATE_START;
        end else if (freeze) begin
            state <= SEC_STOPPED;
        end else begin
            case (state)
                SEC_STOPPED: begin
                    state <= SEC_UPDATE_START;
                end
                SEC_UPDATE_START: begin
                    state <= SEC_UPDATE_IN_PROGRESS;
                end
                SEC_UPDATE_IN_PROGRESS: begin
                    if (count_zero) begin
                        state <= SEC_SECOND_START;
                    end
                end
                SEC_SECOND_START: begin
                    state <= SEC_SECOND_IN_PROGRESS;
                end
                SEC_SECOND_IN_PROGRESS: begin
                    if (countdown == COUNT_W'(1)) begin
                        state <= SEC_UPDATE_START;
                    end
                end
                default: begin
                    state <= SEC_STOPPED;
                end
            endcase
        end
    end

    //////////////////////////////
    // Tick countdown
    //////////////////////////////

    // The count rests at zero until the update window picks it up, so a
    // tick landing on the turnaround never swallows a second.
    always_ff @(posedge clk) begin
        if (!rst_n || freeze) begin
            countdown <= COUNT_W'(FIRST_SECOND_TICKS);
        end else if (count_zero) begin
            if (state == SEC_UPDATE_IN_PROGRESS) begin
                countdown <= COUNT_W'(TICKS_PER_SECOND - 1);
            end
        end else if (tick) begin
            countdown <= countdown - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rtc_time_counter.sv ====
//////////////////////////////
// RTC time counter
// Seconds, minutes and hours with their rollover chain, the
// alarm fields and the alarm match.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_time_counter (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         step,
    rtc_time_if.counter time_bus
);
    import rtc_pkg::*;

    time_byte_t sec_limit;
    time_byte_t hour_limit;
    time_byte_t next_second;
    time_byte_t next_minute;
    time_byte_t next_hour;
    time_byte_t second_after;
    time_byte_t minute_after;
    time_byte_t hour_after;
    logic       minute_adv;
    logic       hour_adv;

    // A field matches when its top bits say "any" or it equals the time.
    function automatic logic field_match(input time_byte_t alarm, input time_byte_t value);
        return (alarm[7:6] == ALARM_ANY) || (alarm == value);
    endfunction

    assign sec_limit  = time_bus.binary_mode ? SEC_LIMIT_BIN : SEC_LIMIT_BCD;
    assign hour_limit = time_bus.binary_mode ? HOUR_LIMIT_BIN : HOUR_LIMIT_BCD;

    assign next_second = next_field(time_bus.second, sec_limit, time_bus.binary_mode);
    assign next_minute = next_field(time_bus.minute, sec_limit, time_bus.binary_mode);
    assign next_hour   = next_field(time_bus.hour, hour_limit, time_bus.binary_mode);

    // A field that comes back as zero has wrapped and carries on.
    assign minute_adv = step && (next_second == '0);
    assign hour_adv   = minute_adv && (next_minute == '0);

    assign second_after = step ? next_second : time_bus.second;
    assign minute_after = minute_adv ? next_minute : time_bus.minute;
    assign hour_after   = hour_adv ? next_hour : time_bus.hour;

    assign time_bus.alarm_hit = field_match(time_bus.alarm_second, second_after) &&
                                field_match(time_bus.alarm_minute, minute_after) &&
                                field_match(time_bus.alarm_hour, hour_after);

    // A host write to a field takes priority over the step for that field only.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            time_bus.second       <= '0;
            time_bus.minute       <= '0;
            time_bus.hour         <= '0;
            time_bus.alarm_second <= '0;
            time_bus.alarm_minute <= '0;
            time_bus.alarm_hour   <= '0;
        end else begin
            if (time_bus.wr_en && time_bus.wr_index == REG_SECONDS) begin
                time_bus.second <= time_bus.wr_data;
            end else begin
                time_bus.second <= second_after;
            end
            if (time_bus.wr_en && time_bus.wr_index == REG_MINUTES) begin
                time_bus.minute <= time_bus.wr_data;
            end else begin
                time_bus.minute <= minute_after;
            end
            if (time_bus.wr_en && time_bus.wr_index == REG_HOURS) begin
                time_bus.hour <= time_bus.wr_data;
            end else begin
                time_bus.hour <= hour_after;
            end
            if (time_bus.wr_en && time_bus.wr_index == REG_ALARM_SECONDS) begin
                time_bus.alarm_second <= time_bus.wr_data;
            end
            if (time_bus.wr_en && time_bus.wr_index == REG_ALARM_MINUTES) begin
                time_bus.alarm_minute <= time_bus.wr_data;
            end
            if (time_bus.wr_en && time_bus.wr_index == REG_ALARM_HOURS) begin
                time_bus.alarm_hour <= time_bus.wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rtc_regs.sv ====
//////////////////////////////
// RTC register block
// Index/data host port, status registers A to D, interrupt
// flags and irq, and the registered read path.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_regs (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       io_address,
    input  wire                       io_read,
    input  wire                       io_write,
    input  wire rtc_pkg::time_byte_t  io_writedata,
    output rtc_pkg::time_byte_t       io_readdata,
    output logic                      irq,
    input  wire                       step,
    input  wire                       update_in_progress,
    output logic                      freeze,
    rtc_time_if.regs                  time_bus
);
    import rtc_pkg::*;

    reg_index_t index;
    logic       alarm_ena;
    logic       update_ena;
    logic       binary_mode;
    logic       alarm_flag;
    logic       update_flag;
    logic       data_write;
    logic       read_c;
    time_byte_t read_mux;

    assign data_write = io_write && io_address;
    assign read_c     = io_read && io_address && (index == REG_STATUS_C);

    assign time_bus.wr_en       = data_write;
    assign time_bus.wr_index    = index;
    assign time_bus.wr_data     = io_writedata;
    assign time_bus.binary_mode = binary_mode;

    //////////////////////////////
    // Index and register B
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index       <= REG_SECONDS;
            freeze      <= 1'b0;
            alarm_ena   <= 1'b0;
            update_ena  <= 1'b0;
            binary_mode <= 1'b0;
        end else if (io_write && !io_address) begin
            index <= reg_index_t'(io_writedata[INDEX_W-1:0]);
        end else if (data_write && index == REG_STATUS_B) begin
            freeze      <= io_writedata[7];
            alarm_ena   <= io_writedata[5];
            // Setting SET also drops the update interrupt enable.
            update_ena  <= io_writedata[4] && !io_writedata[7];
            binary_mode <= io_writedata[2];
        end
    end

    //////////////////////////////
    // Flags and irq
    //////////////////////////////

    // A read of C clears everything on the same edge that latches its value.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else if (read_c) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (step) begin
                update_flag <= 1'b1;
            end
            if (step && time_bus.alarm_hit) begin
                alarm_flag <= 1'b1;
            end
            if (!irq && ((alarm_ena && alarm_flag) || (update_ena && update_flag))) begin
                irq <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    always_comb begin
        read_mux = '0;
        if (!io_address) begin
            read_mux = 8'hFF;
        end else begin
            case (index)
                REG_SECONDS:       read_mux = time_bus.second;
                REG_ALARM_SECONDS: read_mux = time_bus.alarm_second;
                REG_MINUTES:       read_mux = time_bus.minute;
                REG_ALARM_MINUTES: read_mux = time_bus.alarm_minute;
                REG_HOURS:         read_mux = time_bus.hour;
                REG_ALARM_HOURS:   read_mux = time_bus.alarm_hour;
                REG_STATUS_A:      read_mux = {update_in_progress, 7'd0};
                REG_STATUS_B: begin
                    read_mux = {freeze, 1'b0, alarm_ena, update_ena, 1'b0, binary_mode, 2'b00};
                end
                REG_STATUS_C:      read_mux = {irq, 1'b0, alarm_flag, update_flag, 4'h0};
                REG_STATUS_D:      read_mux = 8'h80;
                default:           read_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            io_readdata <= '0;
        end else if (io_read) begin
            io_readdata <= read_mux;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rtc_top.sv ====
//////////////////////////////
// RTC top level
// Prescaler, update sequencer, time counter and register block.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       io_address,
    input  wire                       io_read,
    input  wire                       io_write,
    input  wire rtc_pkg::time_byte_t  io_writedata,
    output wire rtc_pkg::time_byte_t  io_readdata,
    input  wire [rtc_pkg::RATE_W-1:0] clock_rate,
    output wire                       irq
);

    logic tick;
    logic step;
    logic update_in_progress;
    logic freeze;

    rtc_time_if time_bus ();

    rtc_tick_gen u_tick_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .clock_rate (clock_rate),
        .tick       (tick)
    );

    rtc_seq_ctrl u_seq_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .tick               (tick),
        .freeze             (freeze),
        .step               (step),
        .update_in_progress (update_in_progress)
    );

    rtc_time_counter u_time_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step),
        .time_bus (time_bus.counter)
    );

    rtc_regs u_regs (
        .clk                (clk),
        .rst_n              (rst_n),
        .io_address         (io_address),
        .io_read            (io_read),
        .io_write           (io_write),
        .io_writedata       (io_writedata),
        .io_readdata        (io_readdata),
        .irq                (irq),
        .step               (step),
        .update_in_progress (update_in_progress),
        .freeze             (freeze),
        .time_bus           (time_bus.regs)
    );

endmodule

`default_nettype wire

// ==== sim/rtc_checker.sv ====
//////////////////////////////
// RTC read checker
// Compares each host read one cycle after its strobe, and
// watches irq after status C reads and while the clock is frozen.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rtc_checker (
    input wire         clk,
    input wire         rst_n,
    input wire         io_read,
    input wire [7:0]   io_readdata,
    input wire         irq,
    input wire [127:0] test_name,
    input wire [7:0]   expected,
    input wire         compare,
    input wire         irq_low,
    input wire         frozen
);

    int           errors = 0;
    logic         pending;
    logic         pending_irq;
    logic         frozen_reported;
    logic [127:0] name_q;
    logic [7:0]   expected_q;

    // The read data is registered by the DUT, so the value captured with the
    // strobe is compared on the following edge.
    always @(posedge clk) begin
        if (!rst_n) begin
            pending         <= 1'b0;
            pending_irq     <= 1'b0;
            frozen_reported <= 1'b0;
        end else begin
            if (pending && io_readdata !== expected_q) begin
                errors = errors + 1;
                $display("Mismatch in %0s: expected 0x%02h, actual 0x%02h",
                         name_q, expected_q, io_readdata);
            end
            if (pending && pending_irq && irq !== 1'b0) begin
                errors = errors + 1;
                $display("irq is still high after reading register C in %0s", name_q);
            end
            // One report is enough for a frozen window.
            if (frozen && irq === 1'b1 && !frozen_reported) begin
                errors = errors + 1;
                $display("irq rose while the clock was frozen");
                frozen_reported <= 1'b1;
            end
            pending     <= io_read && compare;
            pending_irq <= irq_low;
            name_q      <= test_name;
            expected_q  <= expected;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_rtc.sv ====
//////////////////////////////
// RTC testbench
// Table of time and alarm cases run through the index/data port,
// followed by a freeze check.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rtc;
    import rtc_pkg::*;

    localparam int CLK_HALF_NS     = 20;
    localparam int CYCLE_NS        = 40;
    localparam int CYCLES_PER_STEP = 1600;
    localparam int FREEZE_CYCLES   = 3200;
    localparam int NUM_TESTS       = 7;
    localparam int WATCHDOG_NS     = NUM_TESTS * 3 * CYCLES_PER_STEP * CYCLE_NS;

    typedef struct packed {
        logic [127:0] name;
        logic         bin;
        logic [7:0]   hour;
        logic [7:0]   minute;
        logic [7:0]   second;
        logic [7:0]   al_hour;
        logic [7:0]   al_minute;
        logic [7:0]   al_second;
        logic         aie;
        logic [7:0]   exp_hour;
        logic [7:0]   exp_minute;
        logic [7:0]   exp_second;
        logic [7:0]   exp_c;
    } test_entry_t;

    logic              clk;
    logic              rst_n;
    logic              io_address;
    logic              io_read;
    logic              io_write;
    time_byte_t        io_writedata;
    time_byte_t        io_readdata;
    logic [RATE_W-1:0] clock_rate;
    logic              irq;

    logic [127:0]      check_name;
    time_byte_t        check_value;
    logic              check_read;
    logic              check_irq;
    logic              frozen;
    int                tb_errors;
    test_entry_t       tests [NUM_TESTS];

    always #CLK_HALF_NS clk = ~clk;

    rtc_top u_rtc_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .clock_rate   (clock_rate),
        .irq          (irq)
    );

    rtc_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .io_read     (io_read),
        .io_readdata (io_readdata),
        .irq         (irq),
        .test_name   (check_name),
        .expected    (check_value),
        .compare     (check_read),
        .irq_low     (check_irq),
        .frozen      (frozen)
    );

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    // Each entry holds the name, DM, start h:m:s, alarm h:m:s, AIE, expected h:m:s
    // and expected C.
    task automatic load_tests();
        tests[0] = '{"bcd_day_wrap", 1'b0, 8'h23, 8'h59, 8'h59, 8'h12, 8'h34, 8'h56, 1'b0,
                     8'h00, 8'h00, 8'h00, 8'h90};
        tests[1] = '{"bcd_second", 1'b0, 8'h09, 8'h19, 8'h09, 8'h12, 8'h34, 8'h56, 1'b0,
                     8'h09, 8'h19, 8'h10, 8'h90};
        tests[2] = '{"bin_day_wrap", 1'b1, 8'h17, 8'h3B, 8'h3B, 8'h0C, 8'h22, 8'h38, 1'b0,
                     8'h00, 8'h00, 8'h00, 8'h90};
        tests[3] = '{"bin_minute", 1'b1, 8'h05, 8'h3A, 8'h3B, 8'h0C, 8'h22, 8'h38, 1'b0,
                     8'h05, 8'h3B, 8'h00, 8'h90};
        tests[4] = '{"alarm_exact", 1'b0, 8'h10, 8'h20, 8'h30, 8'h10, 8'h20, 8'h31, 1'b1,
                     8'h10, 8'h20, 8'h31, 8'hB0};
        tests[5] = '{"alarm_wild", 1'b0, 8'h10, 8'h20, 8'h30, 8'hC0, 8'hC0, 8'h31, 1'b1,
                     8'h10, 8'h20, 8'h31, 8'hB0};
        tests[6] = '{"alarm_miss", 1'b0, 8'h10, 8'h20, 8'h30, 8'hC0, 8'hC0, 8'h45, 1'b1,
                     8'h10, 8'h20, 8'h31, 8'h90};
    endtask

    //////////////////////////////
    // Bus tasks
    //////////////////////////////

    // Called 2 ns after a rising edge, and returns at the same offset.
    task automatic bus_write(input logic addr, input time_byte_t data);
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        @(posedge clk);
        #2;
        io_write = 1'b0;
    endtask

    task automatic write_reg(input reg_index_t idx, input time_byte_t data);
        bus_write(1'b0, {1'b0, idx});
        bus_write(1'b1, data);
    endtask

    task automatic read_reg(input reg_index_t idx, input logic [127:0] name,
                            input time_byte_t expected, input logic compare,
                            input logic irq_low);
        bus_write(1'b0, {1'b0, idx});
        io_address  = 1'b1;
        io_read     = 1'b1;
        check_name  = name;
        check_value = expected;
        check_read  = compare;
        check_irq   = irq_low;
        @(posedge clk);
        #2;
        io_read    = 1'b0;
        check_read = 1'b0;
        check_irq  = 1'b0;
    endtask

    task automatic wait_for_irq(input logic [127:0] name);
        int waited;
        waited = 0;
        while (!irq && waited < 2 * CYCLES_PER_STEP) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!irq) begin
            tb_errors++;
            $display("irq never rose in %0s", name);
        end
    endtask

    //////////////////////////////
    // Test sequences
    //////////////////////////////

    task automatic run_entry(input test_entry_t t);
        time_byte_t reg_b;
        reg_b = {2'b00, t.aie, 1'b1, 1'b0, t.bin, 2'b00};
        write_reg(REG_STATUS_B, 8'h80);
        // Drops any flag left over from a step before the clock was frozen.
        read_reg(REG_STATUS_C, t.name, 8'h00, 1'b0, 1'b0);
        write_reg(REG_HOURS, t.hour);
        write_reg(REG_MINUTES, t.minute);
        write_reg(REG_SECONDS, t.second);
        write_reg(REG_ALARM_HOURS, t.al_hour);
        write_reg(REG_ALARM_MINUTES, t.al_minute);
        write_reg(REG_ALARM_SECONDS, t.al_second);
        write_reg(REG_STATUS_B, reg_b);
        wait_for_irq(t.name);
        read_reg(REG_STATUS_C, t.name, t.exp_c, 1'b1, 1'b1);
        read_reg(REG_STATUS_C, t.name, 8'h00, 1'b1, 1'b1);
        read_reg(REG_SECONDS, t.name, t.exp_second, 1'b1, 1'b0);
        read_reg(REG_MINUTES, t.name, t.exp_minute, 1'b1, 1'b0);
        read_reg(REG_HOURS, t.name, t.exp_hour, 1'b1, 1'b0);
    endtask

    // SET written together with AIE and UIE, and UIE must come back cleared.
    // The alarm matches any time, so a single step would raise irq.
    task automatic check_freeze();
        write_reg(REG_STATUS_B, 8'hB0);
        read_reg(REG_STATUS_C, "freeze", 8'h00, 1'b0, 1'b0);
        write_reg(REG_HOURS, 8'h12);
        write_reg(REG_MINUTES, 8'h34);
        write_reg(REG_SECONDS, 8'h56);
        write_reg(REG_ALARM_HOURS, 8'hC0);
        write_reg(REG_ALARM_MINUTES, 8'hC0);
        write_reg(REG_ALARM_SECONDS, 8'hC0);
        frozen = 1'b1;
        repeat (FREEZE_CYCLES) @(posedge clk);
        #2;
        read_reg(REG_STATUS_A, "freeze", 8'h00, 1'b1, 1'b0);
        read_reg(REG_STATUS_B, "freeze", 8'hA0, 1'b1, 1'b0);
        read_reg(REG_SECONDS, "freeze", 8'h56, 1'b1, 1'b0);
        read_reg(REG_MINUTES, "freeze", 8'h34, 1'b1, 1'b0);
        read_reg(REG_HOURS, "freeze", 8'h12, 1'b1, 1'b0);
        frozen = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        io_address   = 1'b0;
        io_read      = 1'b0;
        io_write     = 1'b0;
        io_writedata = '0;
        clock_rate   = RATE_W'(CYCLES_PER_STEP);
        check_name   = '0;
        check_value  = '0;
        check_read   = 1'b0;
        check_irq    = 1'b0;
        frozen       = 1'b0;
        tb_errors    = 0;
        load_tests();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(tests[i]);
        end
        check_freeze();
        repeat (2) @(posedge clk);
        $display("Errors: %0d (checker %0d, testbench %0d)",
                 u_checker.errors + tb_errors, u_checker.errors, tb_errors);
        if (u_checker.errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // The watchdog allows three step periods per table entry.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/rtc_pkg.sv
hw/rtc_time_if.sv
hw/rtc_tick_gen.sv
hw/rtc_seq_ctrl.sv
hw/rtc_time_counter.sv
hw/rtc_regs.sv
hw/rtc_top.sv
sim/rtc_checker.sv
sim/tb_rtc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_rtc
FILELIST  ?= flist.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
